// ==== Bender.yml ====
package:
  name: cart_mem_ctrl

sources:
  - snes_bus_pkg.sv
  - rom_pkg.sv
  - snes_bus_sync.sv
  - lorom_map.sv
  - rom_arbiter.sv
  - rom_port.sv
  - cart_mem_ctrl.sv
  - target: test
    files:
      - cart_mem_ctrl_chk.sv
      - tb_cart_mem_ctrl.sv

// ==== cart_mem_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module cart_mem_ctrl
  import snes_bus_pkg::*;
  import rom_pkg::*;
#(
  parameter int SYNC_DEPTH    = snes_bus_pkg::SYNC_DEPTH,
  parameter int DEAD_TIMEOUT  = snes_bus_pkg::DEAD_TIMEOUT,
  parameter int ROM_CYCLE_LEN = rom_pkg::ROM_CYCLE_LEN
) (
  input  wire                   CLK2,
  input  wire                   rst_n,
  // console pins
  input  wire snes_addr_t       addr_pin,
  input  wire                   rd_n_pin,
  input  wire                   wr_n_pin,
  input  wire                   romsel_n_pin,
  input  wire                   cpu_clk_pin,
  inout  wire snes_data_t       snes_data,
  output logic                  databus_oe_n,
  output logic                  databus_dir,
  // MCU side, wdata held until mcu_rdy rises
  input  wire map_cfg_t         cfg,
  input  wire mcu_req_t         mcu,
  output logic                  mcu_rdy,
  output snes_data_t            mcu_rdata,
  // PSRAM
  output logic [ROM_ADDR_W-2:0] rom_addr,
  inout  wire rom_word_t        rom_data,
  output logic                  rom_we_n,
  output logic                  rom_bhe_n,
  output logic                  rom_ble_n
);

  snes_bus_t  bus;
  snes_evt_t  evt;
  logic       dead;
  map_hit_t   hit;
  arb_grant_t grant;
  snes_data_t rom_rdata;

  snes_bus_sync #(
    .SYNC_DEPTH  (SYNC_DEPTH),
    .DEAD_TIMEOUT(DEAD_TIMEOUT)
  ) sync_i (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .addr_pin    (addr_pin),
    .rd_n_pin    (rd_n_pin),
    .wr_n_pin    (wr_n_pin),
    .romsel_n_pin(romsel_n_pin),
    .cpu_clk_pin (cpu_clk_pin),
    .bus         (bus),
    .evt         (evt),
    .dead        (dead)
  );

  lorom_map map_i (
    .bus(bus),
    .cfg(cfg),
    .hit(hit)
  );

  rom_arbiter #(
    .ROM_CYCLE_LEN(ROM_CYCLE_LEN)
  ) arb_i (
    .CLK2     (CLK2),
    .rst_n    (rst_n),
    .evt      (evt),
    .dead     (dead),
    .hit      (hit),
    .mcu      (mcu),
    .rom_rdata(rom_rdata),
    .mcu_rdy  (mcu_rdy),
    .mcu_rdata(mcu_rdata),
    .grant    (grant)
  );

  rom_port port_i (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .bus         (bus),
    .hit         (hit),
    .grant       (grant),
    .mcu_wdata   (mcu.wdata),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .rom_we_n    (rom_we_n),
    .rom_bhe_n   (rom_bhe_n),
    .rom_ble_n   (rom_ble_n),
    .rom_rdata   (rom_rdata),
    .snes_data   (snes_data),
    .databus_oe_n(databus_oe_n),
    .databus_dir (databus_dir)
  );

endmodule

`default_nettype wire

// ==== cart_mem_ctrl_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module cart_mem_ctrl_chk
  import snes_bus_pkg::*;
  import rom_pkg::*;
(
  input wire             CLK2,
  input wire             rst_n,
  input wire snes_bus_t  bus,
  input wire             dead,
  input wire arb_grant_t grant,
  input wire             mcu_rdy
);

  localparam int RDY_LOW_MAX = 2000;

  int unsigned fail_cnt = 0;

  // no MCU access may start on top of a console ROM read
  grant_start: assert property (@(posedge CLK2) disable iff (!rst_n)
    $rose(grant.active) |-> dead || bus.romsel_n || bus.rd_n)
    else begin
      fail_cnt++;
      $error("MCU grant started during a console ROM read");
    end

  rdy_returns: assert property (@(posedge CLK2) disable iff (!rst_n)
    $fell(mcu_rdy) |-> ##[1:RDY_LOW_MAX] mcu_rdy)
    else begin
      fail_cnt++;
      $error("mcu_rdy held low too long");
    end

endmodule

bind cart_mem_ctrl cart_mem_ctrl_chk chk_i (
  .CLK2   (CLK2),
  .rst_n  (rst_n),
  .bus    (bus),
  .dead   (dead),
  .grant  (grant),
  .mcu_rdy(mcu_rdy)
);

`default_nettype wire

// ==== lorom_map.sv ====
`timescale 1ns/1ns
`default_nettype none

module lorom_map
  import snes_bus_pkg::*;
  import rom_pkg::*;
(
  input  wire snes_bus_t bus,
  input  wire map_cfg_t  cfg,
  output map_hit_t       hit
);

  logic [7:0] bank;
  rom_addr_t  rom_offset;
  rom_addr_t  sram_offset;

  assign bank = bus.addr[23:16];

  always_comb begin
    // upper half of every bank, plus banks 40-7f and c0-ff
    hit.is_rom     = bus.addr[22] | bus.addr[15];
    // banks 70-7d, lower half
    hit.is_saveram = (bank >= 8'h70) && (bank <= 8'h7d) && !bus.addr[15];

    // drop A15 so 32k pages pack back to back
    rom_offset  = {2'b00, bus.addr[22:16], bus.addr[14:0]} & cfg.rom_mask;
    sram_offset = {4'h0, bus.addr[20:16], bus.addr[14:0]} & cfg.saveram_mask;

    // save RAM overlaps the ROM decode and takes priority
    if (hit.is_saveram) begin
      hit.addr = SAVERAM_BASE + sram_offset;
    end else begin
      hit.addr = rom_offset;
    end
  end

endmodule

`default_nettype wire

// ==== rom_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module rom_arbiter
  import snes_bus_pkg::*;
  import rom_pkg::*;
#(
  parameter int ROM_CYCLE_LEN = rom_pkg::ROM_CYCLE_LEN
) (
  input  wire             CLK2,
  input  wire             rst_n,
  input  wire snes_evt_t  evt,
  input  wire             dead,
  input  wire map_hit_t   hit,
  input  wire mcu_req_t   mcu,
  input  wire snes_data_t rom_rdata,
  output logic            mcu_rdy,
  output snes_data_t      mcu_rdata,
  output arb_grant_t      grant
);

  localparam int DLY_W = $clog2(ROM_CYCLE_LEN + 2);

  arb_state_e       state;
  logic [DLY_W-1:0] delay;
  logic             rd_pend;
  logic             wr_pend;
  rom_addr_t        req_addr;
  logic             accept;
  logic             free_strobe;
  logic             free_slot;
  logic             waking;
  logic             wake;

  ////////////////////////////////////////////////////////////////////////////
  // request latch
  ////////////////////////////////////////////////////////////////////////////

  // strobes while busy are dropped
  assign accept = mcu_rdy & (mcu.rrq | mcu.wrq);

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (accept) begin
      // read wins if both strobes come together
      rd_pend <= mcu.rrq;
      wr_pend <= ~mcu.rrq & mcu.wrq;
      mcu_rdy <= 1'b0;
    end else if (state == MCU_END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (accept) begin
      req_addr <= mcu.addr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // free slots
  ////////////////////////////////////////////////////////////////////////////

  // console cycle that does not touch PSRAM
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= evt.cycle_start & ~(hit.is_rom | hit.is_saveram);
    end
  end

  assign free_slot = evt.cycle_end | free_strobe;

  // first CPU clock after a dead phase; hold off until dead drops
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      waking <= 1'b0;
    end else if (!dead) begin
      waking <= 1'b0;
    end else if (evt.cycle_start) begin
      waking <= 1'b1;
    end
  end

  assign wake = dead & (evt.cycle_start | waking);

  ////////////////////////////////////////////////////////////////////////////
  // access FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      delay <= '0;
    end else if (wake) begin
      // abort, pending flag restarts the access later
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if ((free_slot || dead) && (rd_pend || wr_pend)) begin
            state <= rd_pend ? MCU_RD : MCU_WR;
            delay <= DLY_W'(ROM_CYCLE_LEN);
          end
        end
        MCU_RD, MCU_WR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= MCU_END;
          end
        end
        MCU_END: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // last sample before MCU_END is the settled byte
  always_ff @(posedge CLK2) begin
    if (state == MCU_RD) begin
      mcu_rdata <= rom_rdata;
    end
  end

  always_comb begin
    grant.active = (state == MCU_RD) || (state == MCU_WR);
    grant.wr     = (state == MCU_WR);
    grant.addr   = req_addr;
  end

endmodule

`default_nettype wire

// ==== rom_pkg.sv ====
`default_nettype none

package rom_pkg;

  // PSRAM geometry, byte addressed, 16-bit wide
  localparam int ROM_ADDR_W = 24;
  localparam int ROM_DATA_W = 16;
  localparam int MCU_DATA_W = 8;

  // countdown loaded at the start of an MCU access
  localparam int ROM_CYCLE_LEN = 6;

  typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
  typedef logic [ROM_DATA_W-1:0] rom_word_t;

  // save RAM lives at the top of PSRAM
  localparam rom_addr_t SAVERAM_BASE = 24'he00000;

  typedef struct packed {
    rom_addr_t rom_mask;
    rom_addr_t saveram_mask;
  } map_cfg_t;

  typedef struct packed {
    logic      is_rom;
    logic      is_saveram;
    rom_addr_t addr;
  } map_hit_t;

  // rrq and wrq are single-cycle strobes
  typedef struct packed {
    logic                  rrq;
    logic                  wrq;
    rom_addr_t             addr;
    logic [MCU_DATA_W-1:0] wdata;
  } mcu_req_t;

  typedef enum logic [1:0] {
    IDLE,
    MCU_RD,
    MCU_WR,
    MCU_END
  } arb_state_e;

  typedef struct packed {
    logic      active;
    logic      wr;
    rom_addr_t addr;
  } arb_grant_t;

endpackage

`default_nettype wire

// ==== rom_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module rom_port
  import snes_bus_pkg::*;
  import rom_pkg::*;
(
  input  wire                    CLK2,
  input  wire                    rst_n,
  input  wire snes_bus_t         bus,
  input  wire map_hit_t          hit,
  input  wire arb_grant_t        grant,
  input  wire snes_data_t        mcu_wdata,
  output logic [ROM_ADDR_W-2:0]  rom_addr,
  inout  wire rom_word_t         rom_data,
  output logic                   rom_we_n,
  output logic                   rom_bhe_n,
  output logic                   rom_ble_n,
  output snes_data_t             rom_rdata,
  inout  wire snes_data_t        snes_data,
  output logic                   databus_oe_n,
  output logic                   databus_dir
);

  rom_addr_t  addr;
  logic       lane_lo;
  logic       snes_wr;
  logic       mcu_wr;
  snes_data_t wr_byte;
  logic       buf_en;
  logic       snes_rd;
  logic       drive;

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM side
  ////////////////////////////////////////////////////////////////////////////

  assign addr     = grant.active ? grant.addr : hit.addr;
  assign rom_addr = addr[ROM_ADDR_W-1:1];
  assign lane_lo  = addr[0];

  // even bytes sit in the upper lane
  assign rom_bhe_n = lane_lo;
  assign rom_ble_n = ~lane_lo;
  assign rom_rdata = lane_lo ? rom_data[7:0] : rom_data[15:8];

  // console writes only land in save RAM, during the data phase
  assign snes_wr  = hit.is_saveram & bus.cpu_clk & ~bus.wr_n & ~grant.active;
  assign mcu_wr   = grant.active & grant.wr;
  assign rom_we_n = ~(snes_wr | mcu_wr);
  assign wr_byte  = mcu_wr ? mcu_wdata : snes_data;

  assign rom_data[7:0]  = (!rom_we_n && lane_lo) ? wr_byte : 'z;
  assign rom_data[15:8] = (!rom_we_n && !lane_lo) ? wr_byte : 'z;

  ////////////////////////////////////////////////////////////////////////////
  // console data bus
  ////////////////////////////////////////////////////////////////////////////

  // ROM needs romsel, save RAM is decoded from the address alone
  assign buf_en  = ((hit.is_rom & ~bus.romsel_n) | hit.is_saveram)
                   & (~bus.rd_n | ~bus.wr_n);
  assign snes_rd = buf_en & ~bus.rd_n;

  // buffer controls registered so they switch cleanly
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      databus_oe_n <= 1'b1;
      databus_dir  <= 1'b0;
      drive        <= 1'b0;
    end else begin
      databus_oe_n <= ~buf_en;
      databus_dir  <= ~bus.rd_n;
      drive        <= snes_rd;
    end
  end

  assign snes_data = drive ? rom_rdata : 'z;

endmodule

`default_nettype wire

// ==== snes_bus_pkg.sv ====
`default_nettype none

package snes_bus_pkg;

  // console bus widths
  localparam int SNES_ADDR_W = 24;
  localparam int SNES_DATA_W = 8;

  // default oversampling depth, must cover the edge window below
  localparam int SYNC_DEPTH = 7;

  // about 1 ms of CLK2 without a CPU clock edge
  localparam int DEAD_TIMEOUT = 80000;

  // edge patterns on the newest samples, bit 0 is the newest
  localparam int EDGE_W = 6;
  localparam logic [EDGE_W-1:0] EDGE_RISE = 6'b000011;
  localparam logic [EDGE_W-1:0] EDGE_FALL = 6'b111100;

  typedef logic [SNES_ADDR_W-1:0] snes_addr_t;
  typedef logic [SNES_DATA_W-1:0] snes_data_t;

  // filtered console bus
  typedef struct packed {
    snes_addr_t addr;
    logic       rd_n;
    logic       wr_n;
    logic       romsel_n;
    logic       cpu_clk;
  } snes_bus_t;

  // single-cycle bus events
  typedef struct packed {
    logic cycle_start;
    logic cycle_end;
    logic rd_start;
    logic rd_end;
    logic wr_end;
  } snes_evt_t;

  // pin levels of an idle console
  localparam snes_bus_t BUS_IDLE = '{addr: '0, rd_n: 1'b1, wr_n: 1'b1,
                                     romsel_n: 1'b1, cpu_clk: 1'b0};

endpackage

`default_nettype wire

// ==== snes_bus_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

module snes_bus_sync
  import snes_bus_pkg::*;
#(
  parameter int SYNC_DEPTH   = snes_bus_pkg::SYNC_DEPTH,
  parameter int DEAD_TIMEOUT = snes_bus_pkg::DEAD_TIMEOUT
) (
  input  wire             CLK2,
  input  wire             rst_n,
  input  wire snes_addr_t addr_pin,
  input  wire             rd_n_pin,
  input  wire             wr_n_pin,
  input  wire             romsel_n_pin,
  input  wire             cpu_clk_pin,
  output snes_bus_t       bus,
  output snes_evt_t       evt,
  output logic            dead
);

  localparam int CNT_W = $clog2(DEAD_TIMEOUT + 2);

  snes_bus_t [SYNC_DEPTH-1:0] hist;
  snes_bus_t                  pins;
  logic [EDGE_W-1:0]          clk_win;
  logic [EDGE_W-1:0]          rd_win;
  logic [EDGE_W-1:0]          wr_win;
  snes_evt_t                  evt_d;
  logic [CNT_W-1:0]           dead_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // oversampling
  ////////////////////////////////////////////////////////////////////////////

  assign pins = '{addr: addr_pin, rd_n: rd_n_pin, wr_n: wr_n_pin,
                  romsel_n: romsel_n_pin, cpu_clk: cpu_clk_pin};

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      hist <= {SYNC_DEPTH{BUS_IDLE}};
    end else begin
      hist <= {hist[SYNC_DEPTH-2:0], pins};
    end
  end

  // glitch filter on the two oldest stages
  assign bus = hist[SYNC_DEPTH-1] & hist[SYNC_DEPTH-2];

  ////////////////////////////////////////////////////////////////////////////
  // edge events
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < EDGE_W; i++) begin
      clk_win[i] = hist[i].cpu_clk;
      rd_win[i]  = hist[i].rd_n;
      wr_win[i]  = hist[i].wr_n;
    end
  end

  // new level must show in two samples after four of the old one
  always_comb begin
    evt_d.cycle_start = (clk_win == EDGE_RISE);
    evt_d.cycle_end   = (clk_win == EDGE_FALL);
    evt_d.rd_start    = (rd_win == EDGE_FALL);
    evt_d.rd_end      = (rd_win == EDGE_RISE);
    evt_d.wr_end      = (wr_win == EDGE_RISE);
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      evt <= '0;
    end else begin
      evt <= evt_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // dead bus detection
  ////////////////////////////////////////////////////////////////////////////

  // counter saturates, so dead stays up until the clock returns
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt <= '0;
      dead     <= 1'b1;
    end else if (bus.cpu_clk) begin
      dead_cnt <= '0;
      dead     <= 1'b0;
    end else if (dead_cnt < CNT_W'(DEAD_TIMEOUT)) begin
      dead_cnt <= dead_cnt + 1'b1;
    end else begin
      dead <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
snes_bus_pkg.sv
rom_pkg.sv
snes_bus_sync.sv
lorom_map.sv
rom_arbiter.sv
rom_port.sv
cart_mem_ctrl.sv
cart_mem_ctrl_chk.sv
tb_cart_mem_ctrl.sv

// ==== tb_cart_mem_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cart_mem_ctrl
  import snes_bus_pkg::*;
  import rom_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  localparam int DEAD_CYCLES = 64;
  localparam int CYCLE_LEN = rom_pkg::ROM_CYCLE_LEN;
  localparam int N_WORDS = 4096;
  localparam int N_RANDOM = 8;
  // console phase lengths in CLK2 cycles
  localparam int PHASE = 6;
  localparam int TAIL = 4;
  localparam int ALIVE_LIMIT = 200;
  // whole run needs roughly 500 cycles
  localparam int WATCHDOG_CYCLES = 20000;
  localparam rom_addr_t ROM_MASK = 24'h000fff;
  localparam rom_addr_t SRAM_MASK = 24'h000fff;
  localparam rom_addr_t SRAM_BASE = 24'he00000;
  localparam snes_addr_t IDLE_ADDR = 24'h000000;

  typedef enum int {CYC_IDLE, CYC_READ, CYC_WRITE} cyc_kind_e;

  logic                  CLK2 = 1'b0;
  logic                  rst_n;
  snes_addr_t            addr_pin;
  logic                  rd_n_pin;
  logic                  wr_n_pin;
  logic                  romsel_n_pin;
  logic                  cpu_clk_pin;
  wire snes_data_t       snes_data;
  logic                  databus_oe_n;
  logic                  databus_dir;
  map_cfg_t              cfg;
  mcu_req_t              mcu;
  logic                  mcu_rdy;
  snes_data_t            mcu_rdata;
  logic [ROM_ADDR_W-2:0] rom_addr;
  wire rom_word_t        rom_data;
  logic                  rom_we_n;
  logic                  rom_bhe_n;
  logic                  rom_ble_n;

  snes_data_t  snes_drv;
  logic        snes_drv_en;
  rom_word_t   mem [N_WORDS];
  logic [11:0] wr_idx;
  rom_word_t   wr_word;
  logic        wr_bhe_n;
  logic        wr_ble_n;
  logic        wr_open;
  logic [31:0] lfsr;

  always #4 CLK2 = ~CLK2;

  cart_mem_ctrl #(
    .DEAD_TIMEOUT(DEAD_CYCLES)
  ) cart_mem_ctrl_i (.*);

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM model and helpers
  ////////////////////////////////////////////////////////////////////////////

  // save RAM region folds onto the upper half of the model
  function automatic logic [11:0] word_index(input logic [ROM_ADDR_W-2:0] waddr);
    return {waddr[ROM_ADDR_W-2], waddr[10:0]};
  endfunction

  // even byte in the upper lane
  function automatic snes_data_t lane_byte(input rom_word_t w, input logic odd);
    return odd ? w[7:0] : w[15:8];
  endfunction

  function automatic snes_data_t model_byte(input rom_addr_t b);
    return lane_byte(mem[word_index(b[23:1])], b[0]);
  endfunction

  // A15 dropped, then masked
  function automatic rom_addr_t rom_map(input snes_addr_t a);
    return rom_addr_t'({a[22:16], a[14:0]}) & ROM_MASK;
  endfunction

  function automatic rom_addr_t saveram_map(input snes_addr_t a);
    return SRAM_BASE + (rom_addr_t'({a[20:16], a[14:0]}) & SRAM_MASK);
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // upper half of banks 00-3f
  task automatic random_rom_addr(output snes_addr_t sa);
    logic [31:0] r;
    rand_bits(6, r);
    sa[23:16] = {2'b00, r[5:0]};
    rand_bits(15, r);
    sa[15:0] = {1'b1, r[14:0]};
  endtask

  assign rom_data  = rom_we_n ? mem[word_index(rom_addr)] : 'z;
  assign snes_data = snes_drv_en ? snes_drv : 'z;

  // write lands when we_n goes back high
  always @(posedge CLK2) begin
    if (!rom_we_n) begin
      wr_idx   = word_index(rom_addr);
      wr_word  = rom_data;
      wr_bhe_n = rom_bhe_n;
      wr_ble_n = rom_ble_n;
      wr_open  = 1'b1;
    end else if (wr_open) begin
      if (!wr_bhe_n) begin
        mem[wr_idx][15:8] = wr_word[15:8];
      end
      if (!wr_ble_n) begin
        mem[wr_idx][7:0] = wr_word[7:0];
      end
      wr_open = 1'b0;
    end
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic mcu_access(input logic wr, input rom_addr_t a, input snes_data_t wdata,
                            input int limit, output snes_data_t rdata);
    int   waited;
    logic we_seen;
    waited  = 0;
    we_seen = 1'b0;
    @(negedge CLK2);
    mcu = '{rrq: !wr, wrq: wr, addr: a, wdata: wdata};
    @(negedge CLK2);
    mcu.rrq = 1'b0;
    mcu.wrq = 1'b0;
    assert (!mcu_rdy)
      else stop_run($sformatf("mismatch mcu_rdy: got %h expected %h", mcu_rdy, 1'b0));
    while (!mcu_rdy) begin
      if (wr && !rom_we_n) begin
        we_seen = 1'b1;
        assert (rom_addr == a[23:1])
          else stop_run($sformatf("mismatch rom_addr: got %h expected %h", rom_addr, a[23:1]));
        assert (lane_byte(rom_data, a[0]) == wdata)
          else stop_run($sformatf("mismatch rom_data lane: got %h expected %h",
                                  lane_byte(rom_data, a[0]), wdata));
        assert ({rom_bhe_n, rom_ble_n} == {a[0], !a[0]})
          else stop_run($sformatf("mismatch rom_bhe_n,rom_ble_n: got %h expected %h",
                                  {rom_bhe_n, rom_ble_n}, {a[0], !a[0]}));
      end
      @(negedge CLK2);
      waited++;
      if (waited > limit) begin
        stop_run("mcu_rdy did not return high in time");
      end
    end
    if (wr) begin
      assert (we_seen) else stop_run("no PSRAM write pulse for an MCU write");
    end
    rdata = mcu_rdata;
  endtask

  // one console cycle with the data phase while cpu_clk is high
  task automatic console_cycle(input snes_addr_t a, input cyc_kind_e kind,
                               input snes_data_t wdata);
    snes_data_t exp;
    exp = model_byte(rom_map(a));
    @(negedge CLK2);
    addr_pin     = a;
    romsel_n_pin = !(a[22] | a[15]);
    rd_n_pin     = (kind != CYC_READ);
    wr_n_pin     = 1'b1;
    cpu_clk_pin  = 1'b0;
    repeat (PHASE) @(negedge CLK2);
    cpu_clk_pin = 1'b1;
    if (kind == CYC_WRITE) begin
      wr_n_pin    = 1'b0;
      snes_drv    = wdata;
      snes_drv_en = 1'b1;
    end
    repeat (PHASE - 1) @(negedge CLK2);
    if (kind == CYC_READ) begin
      assert (snes_data == exp)
        else stop_run($sformatf("mismatch snes_data: got %h expected %h", snes_data, exp));
      assert (!databus_oe_n)
        else stop_run($sformatf("mismatch databus_oe_n: got %h expected %h",
                                databus_oe_n, 1'b0));
      assert (databus_dir)
        else stop_run($sformatf("mismatch databus_dir: got %h expected %h",
                                databus_dir, 1'b1));
    end
    @(negedge CLK2);
    rd_n_pin = 1'b1;
    wr_n_pin = 1'b1;
    repeat (TAIL) @(negedge CLK2);
    cpu_clk_pin = 1'b0;
    // filtered bus lags the pins, so hold the byte a while
    if (kind == CYC_WRITE) begin
      repeat (10) @(negedge CLK2);
      snes_drv_en = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    snes_data_t  got;
    snes_data_t  d;
    rom_addr_t   a;
    snes_addr_t  sa;
    logic [31:0] r;
    logic [7:0]  ref_bytes [rom_addr_t];
    rom_addr_t   written [$];
    lfsr         = 32'h6c7e_5851;
    rst_n        = 1'b0;
    addr_pin     = IDLE_ADDR;
    rd_n_pin     = 1'b1;
    wr_n_pin     = 1'b1;
    romsel_n_pin = 1'b1;
    cpu_clk_pin  = 1'b0;
    cfg          = '{rom_mask: ROM_MASK, saveram_mask: SRAM_MASK};
    mcu          = '0;
    snes_drv     = '0;
    snes_drv_en  = 1'b0;
    wr_open      = 1'b0;
    for (int i = 0; i < N_WORDS; i++) begin
      mem[i] = 16'(i * 40503) ^ 16'h5a5a;
    end
    repeat (RESET_CYCLES) @(posedge CLK2);
    @(negedge CLK2);
    rst_n = 1'b1;
    @(negedge CLK2);
    assert (mcu_rdy)
      else stop_run($sformatf("mismatch mcu_rdy: got %h expected %h", mcu_rdy, 1'b1));
    assert (rom_we_n)
      else stop_run($sformatf("mismatch rom_we_n: got %h expected %h", rom_we_n, 1'b1));
    assert (databus_oe_n)
      else stop_run($sformatf("mismatch databus_oe_n: got %h expected %h",
                              databus_oe_n, 1'b1));

    // MCU writes to ROM and save RAM on a dead bus
    repeat (N_RANDOM) begin
      rand_bits(1, r);
      a = r[0] ? SRAM_BASE : '0;
      rand_bits(12, r);
      a = a | rom_addr_t'(r[11:0]);
      rand_bits(8, r);
      d = r[7:0];
      mcu_access(1'b1, a, d, CYCLE_LEN + 4, got);
      ref_bytes[a] = d;
      written.push_back(a);
    end
    foreach (written[i]) begin
      mcu_access(1'b0, written[i], '0, CYCLE_LEN + 4, got);
      assert (got == ref_bytes[written[i]])
        else stop_run($sformatf("mismatch mcu_rdata: got %h expected %h",
                                got, ref_bytes[written[i]]));
    end

    // console reads from the upper half of banks 00-3f
    repeat (N_RANDOM) begin
      random_rom_addr(sa);
      console_cycle(sa, CYC_READ, '0);
    end
    console_cycle(IDLE_ADDR, CYC_IDLE, '0);

    // console write to save RAM and MCU read back on a live bus
    rand_bits(15, r);
    sa = {8'h70, 1'b0, r[14:0]};
    rand_bits(8, r);
    d = r[7:0];
    console_cycle(sa, CYC_WRITE, d);
    a = saveram_map(sa);
    assert (model_byte(a) == d)
      else stop_run($sformatf("mismatch save RAM byte: got %h expected %h", model_byte(a), d));
    // the request arrives during a ROM read and has to wait for a free slot
    fork
      mcu_access(1'b0, a, '0, ALIVE_LIMIT, got);
      begin
        repeat (4) begin
          random_rom_addr(sa);
          console_cycle(sa, CYC_READ, '0);
          console_cycle(IDLE_ADDR, CYC_IDLE, '0);
        end
      end
    join
    assert (got == d)
      else stop_run($sformatf("mismatch mcu_rdata: got %h expected %h", got, d));

    repeat (4) @(negedge CLK2);
    if (cart_mem_ctrl_i.chk_i.fail_cnt != 0) begin
      stop_run("bound checker reported a failed assertion");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

  always @(negedge CLK2) begin
    if (cart_mem_ctrl_i.chk_i.fail_cnt != 0) begin
      stop_run("bound checker reported a failed assertion");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK2);
    stop_run("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire
